//--- common/lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// System clocks per sclk period, must be even
`define LCD_CLK_DIV 4

// Execution wait after an ordinary instruction, in clocks
`define LCD_WAIT_SHORT 40

// Execution wait after clear or home
`define LCD_WAIT_LONG 400

// Entries in the init table
`define LCD_INIT_LEN 5

// Upper five bits of the sync byte
`define LCD_SYNC 5'b11111

`endif

//--- common/lcd_pkg.sv
package lcd_pkg;

    // One LCD instruction or data byte
    typedef logic [7:0] lcd_byte_t;

    // Half of an instruction, sent in the top of a serial byte
    typedef logic [3:0] lcd_nibble_t;

    // Position inside a frame: 0 sync, 1 high nibble, 2 low nibble
    typedef logic [1:0] frame_idx_t;

    // Execution wait counter
    typedef logic [15:0] wait_cnt_t;

    // Init table index
    typedef logic [2:0] init_idx_t;

    // Controller FSM
    typedef enum logic [2:0] {
        INIT_LOAD = 3'd0,   // Load next init table entry into the frame
        SEND      = 3'd1,   // Kick off one SPI byte
        WAIT_SPI  = 3'd2,   // Byte on the wire
        WAIT_EXEC = 3'd3,   // LCD execution time
        IDLE      = 3'd4    // Host may hand over an item
    } ctrl_state_t;

endpackage

//--- spi/spi_tx.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module spi_tx #(
    parameter int WIDTH   = 8,              // Bits per transfer
    parameter int CLK_DIV = `LCD_CLK_DIV    // System clocks per sclk period, even
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start,         // One-cycle request, sampled in idle
    input  logic [WIDTH-1:0] data_in,
    output logic             sdo,
    output logic             sclk,
    output logic             cs_n,
    output logic             busy,
    output logic             done           // One cycle after the trail
);

    localparam int HALF  = CLK_DIV / 2;
    localparam int DIV_W = $clog2(CLK_DIV);
    localparam int BIT_W = $clog2(WIDTH + 1);

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_LEAD,
        TX_ACTIVE,
        TX_TRAIL,
        TX_FINISH
    } tx_state_t;

    tx_state_t        state;
    tx_state_t        state_nxt;
    logic [DIV_W-1:0] div_cnt;      // Lead/trail length or half-period count
    logic [BIT_W-1:0] bit_cnt;      // Falling edges seen so far
    logic [WIDTH-1:0] shift_reg;
    logic             sclk_int;
    logic             toggle;
    logic             phase_end;

    assign toggle    = (state == TX_ACTIVE) && (div_cnt == DIV_W'(HALF - 1));
    assign phase_end = (div_cnt == DIV_W'(CLK_DIV - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            TX_IDLE: begin
                if (start) state_nxt = TX_LEAD;
            end
            TX_LEAD: begin
                if (phase_end) state_nxt = TX_ACTIVE;
            end
            TX_ACTIVE: begin
                // Leave on the last rising edge, sclk then parks high
                if (toggle && !sclk_int && bit_cnt == BIT_W'(WIDTH - 1)) begin
                    state_nxt = TX_TRAIL;
                end
            end
            TX_TRAIL: begin
                if (phase_end) state_nxt = TX_FINISH;
            end
            TX_FINISH: state_nxt = TX_IDLE;
            default:   state_nxt = TX_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            sclk_int <= 1'b0;
        end else begin
            state <= state_nxt;

            // Restart the count on every phase change and every sclk edge
            if (state == TX_IDLE || state_nxt != state || toggle) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (state == TX_ACTIVE) begin
                if (toggle) sclk_int <= ~sclk_int;
            end else begin
                sclk_int <= 1'b0;   // First active cycle drops sclk
            end

            if (state == TX_IDLE) begin
                bit_cnt <= '0;
            end else if (toggle && sclk_int) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Load on start, shift on the falling edge so sdo is stable at the rise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift_reg <= '0;
        end else if (state == TX_IDLE && start) begin
            shift_reg <= data_in;
        end else if (toggle && sclk_int) begin
            shift_reg <= shift_reg << 1;
        end
    end

    assign sclk = (state == TX_ACTIVE) ? sclk_int : 1'b1;
    assign sdo  = shift_reg[WIDTH-1];     // MSB first
    assign cs_n = (state == TX_IDLE) || (state == TX_FINISH);
    assign busy = ~cs_n;
    assign done = (state == TX_FINISH);

endmodule

//--- hw/lcd_init_rom.sv
`timescale 1ns/1ps

module lcd_init_rom (
    input  lcd_pkg::init_idx_t rom_idx,
    output lcd_pkg::lcd_byte_t rom_data,
    output logic               rom_long
);

    import lcd_pkg::*;

    always_comb begin
        rom_long = 1'b0;
        case (rom_idx)
            init_idx_t'(0): rom_data = 8'h30;   // Function set
            init_idx_t'(1): rom_data = 8'h30;   // Function set, repeated
            init_idx_t'(2): rom_data = 8'h0C;   // Display on, cursor off
            init_idx_t'(3): begin
                rom_data = 8'h01;               // Clear
                rom_long = 1'b1;
            end
            init_idx_t'(4): rom_data = 8'h06;   // Entry mode, increment
            default:        rom_data = 8'h00;
        endcase
    end

endmodule

//--- hw/lcd_frame.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_frame (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               frame_load,
    input  logic               frame_next,
    input  logic               frame_rs,
    input  lcd_pkg::lcd_byte_t frame_data,
    output lcd_pkg::lcd_byte_t frame_byte,
    output logic               frame_last
);

    import lcd_pkg::*;

    frame_idx_t  idx;
    logic        rs_q;
    lcd_byte_t   data_q;
    lcd_nibble_t nib_hi;
    lcd_nibble_t nib_lo;

    always_ff @(posedge clk) begin
        if (frame_load) begin
            rs_q   <= frame_rs;
            data_q <= frame_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (frame_load) begin
            idx <= '0;
        end else if (frame_next && !frame_last) begin
            idx <= idx + 1'b1;
        end
    end

    assign nib_hi = data_q[7:4];
    assign nib_lo = data_q[3:0];

    always_comb begin
        case (idx)
            2'd0:    frame_byte = {`LCD_SYNC, 1'b0, rs_q, 1'b0};   // RW always 0
            2'd1:    frame_byte = {nib_hi, 4'b0000};
            default: frame_byte = {nib_lo, 4'b0000};
        endcase
    end

    assign frame_last = (idx == frame_idx_t'(2));

endmodule

//--- hw/lcd_wait.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_wait (
    input  logic clk,
    input  logic rst_n,
    input  logic wait_start,
    input  logic wait_long,
    output logic wait_done
);

    import lcd_pkg::*;

    wait_cnt_t count;
    logic      running;

    // Loaded one short of the length so done lands exactly on it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count   <= '0;
            running <= 1'b0;
        end else if (wait_start) begin
            count   <= wait_long ? wait_cnt_t'(`LCD_WAIT_LONG - 1)
                                 : wait_cnt_t'(`LCD_WAIT_SHORT - 1);
            running <= 1'b1;
        end else if (running) begin
            if (count == '0) begin
                running <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    assign wait_done = running && (count == '0);

endmodule

//--- hw/lcd_ctrl.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 host_valid,
    input  logic                 host_rs,
    input  lcd_pkg::lcd_byte_t   host_data,
    input  lcd_pkg::lcd_byte_t   rom_data,
    input  logic                 rom_long,
    input  logic                 frame_last,
    input  logic                 tx_done,
    input  logic                 wait_done,
    output logic                 host_ready,
    output lcd_pkg::init_idx_t   rom_idx,
    output logic                 frame_load,
    output logic                 frame_rs,
    output lcd_pkg::lcd_byte_t   frame_data,
    output logic                 frame_next,
    output logic                 tx_start,
    output logic                 wait_start,
    output logic                 wait_long
);

    import lcd_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        init_run;      // Init table still being walked
    logic        long_q;        // Wait length of the frame in flight
    logic        host_long;
    logic        host_take;
    logic        init_last;

    // Clear is 0x01, home is 0x02 or 0x03, both only as instructions
    assign host_long = !host_rs &&
                       (host_data == 8'h01 || host_data[7:1] == 7'b0000001);
    assign init_last = (rom_idx == init_idx_t'(`LCD_INIT_LEN - 1));

    assign host_ready = (state == IDLE) && !init_run;
    assign host_take  = host_ready && host_valid;

    // Frame source is the ROM during init, the host otherwise
    assign frame_load = (state == INIT_LOAD) || host_take;
    assign frame_rs   = (state == INIT_LOAD) ? 1'b0 : host_rs;
    assign frame_data = (state == INIT_LOAD) ? rom_data : host_data;

    assign tx_start   = (state == SEND);
    assign frame_next = (state == WAIT_SPI) && tx_done && !frame_last;
    assign wait_start = (state == WAIT_SPI) && tx_done && frame_last;
    assign wait_long  = long_q;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (init_run) begin
                    state_nxt = INIT_LOAD;      // First cycle out of reset
                end else if (host_valid) begin
                    state_nxt = SEND;
                end
            end
            INIT_LOAD: state_nxt = SEND;
            SEND:      state_nxt = WAIT_SPI;
            WAIT_SPI: begin
                if (tx_done) begin
                    state_nxt = frame_last ? WAIT_EXEC : SEND;
                end
            end
            WAIT_EXEC: begin
                if (wait_done) begin
                    state_nxt = (init_run && !init_last) ? INIT_LOAD : IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            init_run <= 1'b1;
            rom_idx  <= '0;
            long_q   <= 1'b0;
        end else begin
            state <= state_nxt;

            if (state == INIT_LOAD) begin
                long_q <= rom_long;
            end else if (host_take) begin
                long_q <= host_long;
            end

            // Step the table once the entry's wait has run out
            if (state == WAIT_EXEC && wait_done && init_run) begin
                if (init_last) begin
                    init_run <= 1'b0;
                end else begin
                    rom_idx <= rom_idx + 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/lcd_spi_top.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_spi_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               host_valid,
    input  logic               host_rs,
    input  lcd_pkg::lcd_byte_t host_data,
    output logic               host_ready,
    output logic               sdo,
    output logic               sclk,
    output logic               cs_n
);

    import lcd_pkg::*;

    init_idx_t rom_idx;
    lcd_byte_t rom_data;
    logic      rom_long;
    logic      frame_load;
    logic      frame_next;
    logic      frame_rs;
    lcd_byte_t frame_data;
    lcd_byte_t frame_byte;
    logic      frame_last;
    logic      tx_start;
    logic      tx_done;
    logic      wait_start;
    logic      wait_long;
    logic      wait_done;

    lcd_ctrl i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_valid (host_valid),
        .host_rs    (host_rs),
        .host_data  (host_data),
        .rom_data   (rom_data),
        .rom_long   (rom_long),
        .frame_last (frame_last),
        .tx_done    (tx_done),
        .wait_done  (wait_done),
        .host_ready (host_ready),
        .rom_idx    (rom_idx),
        .frame_load (frame_load),
        .frame_rs   (frame_rs),
        .frame_data (frame_data),
        .frame_next (frame_next),
        .tx_start   (tx_start),
        .wait_start (wait_start),
        .wait_long  (wait_long)
    );

    lcd_init_rom i_init_rom (
        .rom_idx  (rom_idx),
        .rom_data (rom_data),
        .rom_long (rom_long)
    );

    lcd_frame i_frame (
        .clk        (clk),
        .rst_n      (rst_n),
        .frame_load (frame_load),
        .frame_next (frame_next),
        .frame_rs   (frame_rs),
        .frame_data (frame_data),
        .frame_byte (frame_byte),
        .frame_last (frame_last)
    );

    lcd_wait i_wait (
        .clk        (clk),
        .rst_n      (rst_n),
        .wait_start (wait_start),
        .wait_long  (wait_long),
        .wait_done  (wait_done)
    );

    spi_tx #(
        .WIDTH   ($bits(lcd_byte_t)),
        .CLK_DIV (`LCD_CLK_DIV)
    ) i_spi_tx (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (tx_start),
        .data_in (frame_byte),
        .sdo     (sdo),
        .sclk    (sclk),
        .cs_n    (cs_n),
        .busy    (),
        .done    (tx_done)
    );

endmodule

//--- sim/lcd_spi_checker.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_spi_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               host_valid,
    input  logic               host_rs,
    input  lcd_pkg::lcd_byte_t host_data,
    input  logic               host_ready,
    input  logic               sdo,
    input  logic               sclk,
    input  logic               cs_n
);

    import lcd_pkg::*;

    // LCD init table: function set twice, display on, clear, entry mode
    localparam lcd_byte_t INIT_TAB [5] = '{8'h30, 8'h30, 8'h0C, 8'h01, 8'h06};
    localparam int CLEAR_IDX = 3;
    localparam int INIT_BYTES = 3 * `LCD_INIT_LEN;

    int        fail_cnt = 0;   // Read by the testbench
    lcd_byte_t exp_mem [64];   // Expected bytes in bus order
    logic      long_mem [32];  // Long wait flag per frame
    int        wr_ptr;
    int        rd_ptr;
    int        frame_wr;
    int        frame_rd;
    logic      sclk_q;
    logic      cs_n_q;
    logic      sdo_q;
    lcd_byte_t rx_byte;
    int        rx_bits;
    int        byte_pos;       // 0 sync, 1 high, 2 low
    logic      gap_armed;      // Last byte of a frame seen, gap not yet closed
    int        gap_need;
    int        gap_cnt;
    logic      sclk_rise;
    logic      byte_end;
    logic      cs_fall;
    logic      exp_valid;
    lcd_byte_t exp_head;

    // Serial byte for one position of a frame
    function automatic lcd_byte_t serial_byte(int pos, logic rs, lcd_byte_t data);
        case (pos)
            0:       return {`LCD_SYNC, 1'b0, rs, 1'b0};
            1:       return {data[7:4], 4'h0};
            default: return {data[3:0], 4'h0};
        endcase
    endfunction

    // Clear and home take the long execution time
    function automatic logic needs_long(logic rs, lcd_byte_t data);
        return !rs && (data == 8'h01 || data == 8'h02 || data == 8'h03);
    endfunction

    assign sclk_rise = !cs_n && sclk && !sclk_q;
    assign byte_end  = cs_n && !cs_n_q;
    assign cs_fall   = !cs_n && cs_n_q;
    assign exp_valid = rd_ptr < wr_ptr;
    assign exp_head  = exp_mem[rd_ptr % 64];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sclk_q    <= 1'b1;
            cs_n_q    <= 1'b1;
            sdo_q     <= 1'b0;
            rx_byte   <= '0;
            rx_bits   <= 0;
            byte_pos  <= 0;
            gap_armed <= 1'b0;
            gap_need  <= 0;
            gap_cnt   <= 0;
            rd_ptr    <= 0;
            frame_rd  <= 0;
            for (int i = 0; i < `LCD_INIT_LEN; i++) begin
                for (int p = 0; p < 3; p++) begin
                    exp_mem[i*3+p] <= serial_byte(p, 1'b0, INIT_TAB[i]);
                end
                long_mem[i] <= (i == CLEAR_IDX);
            end
            wr_ptr   <= INIT_BYTES;
            frame_wr <= `LCD_INIT_LEN;
        end else begin
            sclk_q <= sclk;
            cs_n_q <= cs_n;
            sdo_q  <= sdo;

            if (sclk_rise) begin
                rx_byte <= {rx_byte[6:0], sdo};   // MSB first
                rx_bits <= rx_bits + 1;
            end else if (cs_n && cs_n_q) begin
                rx_bits <= 0;
            end

            if (byte_end) begin
                rd_ptr <= rd_ptr + 1;
                if (byte_pos == 2) begin
                    byte_pos  <= 0;
                    frame_rd  <= frame_rd + 1;
                    gap_armed <= 1'b1;
                    gap_need  <= long_mem[frame_rd % 32] ? `LCD_WAIT_LONG : `LCD_WAIT_SHORT;
                end else begin
                    byte_pos <= byte_pos + 1;
                end
            end
            if (cs_fall) gap_armed <= 1'b0;

            gap_cnt <= cs_n ? gap_cnt + 1 : 0;   // High cycles since the last rise

            if (host_valid && host_ready) begin
                for (int p = 0; p < 3; p++) begin
                    exp_mem[(wr_ptr + p) % 64] <= serial_byte(p, host_rs, host_data);
                end
                long_mem[frame_wr % 32] <= needs_long(host_rs, host_data);
                wr_ptr   <= wr_ptr + 3;
                frame_wr <= frame_wr + 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> (cs_n && sclk && !host_ready))
        else begin fail_cnt++; $error("bus or host_ready active during reset"); end

    a_ready_after_init: assert property (@(posedge clk) disable iff (!rst_n)
        host_ready |-> rd_ptr >= INIT_BYTES)
        else begin fail_cnt++; $error("host_ready high before init frames done"); end

    a_sdo_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (!cs_n && !cs_n_q && sclk) |-> sdo == sdo_q)
        else begin fail_cnt++; $error("sdo changed while sclk high"); end

    a_eight_bits: assert property (@(posedge clk) disable iff (!rst_n)
        byte_end |-> rx_bits == 8)
        else begin fail_cnt++; $error("transfer with %0d sclk rises", rx_bits); end

    a_byte_known: assert property (@(posedge clk) disable iff (!rst_n)
        byte_end |-> exp_valid)
        else begin fail_cnt++; $error("byte on bus with no item behind it"); end

    a_byte_value: assert property (@(posedge clk) disable iff (!rst_n)
        byte_end |-> rx_byte == exp_head)
        else begin fail_cnt++; $error("byte %0d got %h exp %h", rd_ptr, rx_byte, exp_head); end

    a_exec_gap: assert property (@(posedge clk) disable iff (!rst_n)
        (cs_fall && gap_armed) |-> gap_cnt >= gap_need)
        else begin fail_cnt++; $error("gap %0d below %0d", gap_cnt, gap_need); end

endmodule

bind lcd_spi_top lcd_spi_checker i_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_valid (host_valid),
    .host_rs    (host_rs),
    .host_data  (host_data),
    .host_ready (host_ready),
    .sdo        (sdo),
    .sclk       (sclk),
    .cs_n       (cs_n)
);

//--- sim/tb_lcd_spi.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module tb_lcd_spi;

    import lcd_pkg::*;

    localparam int ITEMS     = 12;
    localparam int CLEAR_AT  = 5;      // Item forced to a clear
    localparam int WAIT_MAX  = 5000;   // Cycles per wait loop

    logic      clk = 1'b0;
    logic      rst_n;
    logic      host_valid;
    logic      host_rs;
    lcd_byte_t host_data;
    logic      host_ready;
    logic      sdo;
    logic      sclk;
    logic      cs_n;

    int        timeout_errs = 0;
    int        count_errs = 0;
    int        chk_errs;
    int        exp_bytes;
    logic      timed_out = 1'b0;

    always #2 clk = ~clk;

    lcd_spi_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_valid (host_valid),
        .host_rs    (host_rs),
        .host_data  (host_data),
        .host_ready (host_ready),
        .sdo        (sdo),
        .sclk       (sclk),
        .cs_n       (cs_n)
    );

    // Poll host_ready just after each edge
    task automatic wait_ready();
        int cnt;
        cnt = 0;
        while (!host_ready && !timed_out) begin
            @(posedge clk);
            #1;
            cnt++;
            if (cnt > WAIT_MAX) begin
                timed_out = 1'b1;
                timeout_errs++;
                $display("timeout at %0t: host_ready never rose", $time);
            end
        end
    endtask

    task automatic send_item(logic rs, lcd_byte_t data, logic early);
        host_rs   = rs;
        host_data = data;
        if (early) host_valid = 1'b1;   // Raised while still blocked
        wait_ready();
        host_valid = 1'b1;
        @(posedge clk);                 // Transfer edge
        #1;
        host_valid = 1'b0;
    endtask

    initial begin
        int        gap;
        logic      rs;
        lcd_byte_t data;

        void'($urandom(14067));
        rst_n      = 1'b0;
        host_valid = 1'b0;
        host_rs    = 1'b0;
        host_data  = '0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < ITEMS; i++) begin
            if (!timed_out) begin
                gap = $urandom % 6;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                rs   = 1'($urandom % 2);
                data = 8'($urandom);
                if (i == CLEAR_AT) begin
                    rs   = 1'b0;
                    data = 8'h01;
                end
                send_item(rs, data, ($urandom % 2) == 1);
            end
        end

        wait_ready();   // Last frame and its wait are over
        repeat (4) @(posedge clk);

        exp_bytes = 3 * (`LCD_INIT_LEN + ITEMS);
        if (!timed_out && i_dut.i_checker.rd_ptr != exp_bytes) begin
            count_errs++;
            $display("error at %0t: decoded %0d bytes, expected %0d",
                     $time, i_dut.i_checker.rd_ptr, exp_bytes);
        end
        chk_errs = i_dut.i_checker.fail_cnt;
        $display("timeout errors %0d, count errors %0d, checker errors %0d",
                 timeout_errs, count_errs, chk_errs);
        if (timeout_errs == 0 && count_errs == 0 && chk_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+common
common/lcd_pkg.sv
spi/spi_tx.sv
hw/lcd_init_rom.sv
hw/lcd_frame.sv
hw/lcd_wait.sv
hw/lcd_ctrl.sv
hw/lcd_spi_top.sv
sim/lcd_spi_checker.sv
sim/tb_lcd_spi.sv

//--- Makefile
.PHONY: compile run clean

BIN = obj_dir/Vtb_lcd_spi

compile: $(BIN)

$(BIN): tb.f
	verilator --binary --assert --timing -f tb.f --top-module tb_lcd_spi -o Vtb_lcd_spi

run: compile
	@out=$$(./$(BIN) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
